// ==== common/soc_bus_pkg.sv ====
`default_nettype none

package soc_bus_pkg;

    // Bus widths
    localparam int BUS_ADDR_W = 32;
    localparam int BUS_DATA_W = 32;

    // Top address bits used for the chip selects
    localparam int SEL_W = 8;

    // Address map, one select value per slave
    localparam logic [SEL_W-1:0] GPIO_BASE = 8'h40;
    localparam logic [SEL_W-1:0] UART_BASE = 8'h60;

    // UART sees the data word as a byte
    typedef struct packed {
        logic [BUS_DATA_W-9:0] unused;
        logic [7:0]            tx_byte;
    } uart_view_t;

    // GPIO sees the data word as a single level bit
    typedef struct packed {
        logic [BUS_DATA_W-2:0] unused;
        logic                  level;
    } gpio_view_t;

    typedef union packed {
        uart_view_t uart;
        gpio_view_t gpio;
    } bus_data_u;

endpackage

`default_nettype wire

// ==== common/soc_periph_pkg.sv ====
`default_nettype none

package soc_periph_pkg;

    // wb_clk cycles per UART bit
    localparam int UART_DIVIDE = 32;
    localparam int BAUD_CNT_W  = $clog2(UART_DIVIDE);

    // Start, eight data bits and stop
    localparam int UART_FRAME_BITS = 10;
    localparam int UART_CNT_W      = $clog2(UART_FRAME_BITS + 1);

    // GPIO output level after reset
    localparam logic GPIO_RESET_LEVEL = 1'b0;

    // Internal reset hold time after the external reset releases
    localparam int RST_STRETCH = 5;

endpackage

`default_nettype wire

// ==== common/periph_bus_if.sv ====
`default_nettype none

interface periph_bus_if;
    import soc_bus_pkg::*;

    // Decoded select for this slave
    logic      cyc_sel;
    logic      we;
    bus_data_u wdat;
    bus_data_u rdt;

    // Owned by the decoder, not the peripheral
    logic      ack;

    modport ctrl (
        output cyc_sel,
        output we,
        output wdat,
        output ack,
        input  rdt
    );

    modport periph (
        input  cyc_sel,
        input  we,
        input  wdat,
        output rdt
    );

endinterface

`default_nettype wire

// ==== verilog/reset_stretch.sv ====
`default_nettype none

module reset_stretch (
    input  wire  wb_clk,
    input  wire  i_rst_n,
    output logic o_rst
);
    import soc_periph_pkg::*;

    logic [RST_STRETCH-1:0] rst_shift;

    // Fill with ones while external reset is low, then drain with zeros
    always_ff @(posedge wb_clk) begin
        if (!i_rst_n) begin
            rst_shift <= '1;
        end else begin
            rst_shift <= {1'b0, rst_shift[RST_STRETCH-1:1]};
        end
    end

    // Last stage is the bus reset
    assign o_rst = rst_shift[0];

endmodule

`default_nettype wire

// ==== verilog/bus_select.sv ====
`default_nettype none

module bus_select #(
    parameter logic [soc_bus_pkg::SEL_W-1:0] SLAVE_SEL = '0
) (
    input  wire                                wb_clk,
    input  wire                                i_rst,
    input  wire                                i_wb_cyc,
    input  wire                                i_wb_we,
    input  wire [soc_bus_pkg::BUS_DATA_W-1:0]  i_wb_dat,
    input  wire [soc_bus_pkg::SEL_W-1:0]       i_sel_adr,
    periph_bus_if.ctrl                         bus
);

    logic sel;
    logic ack_q;

    // Chip select from the top address byte
    assign sel = i_wb_cyc && (i_sel_adr == SLAVE_SEL);

    assign bus.cyc_sel = sel;
    assign bus.we      = i_wb_we;
    assign bus.wdat    = i_wb_dat;

    // Single-cycle ack, one edge after the select rises.
    // Holding off while ack is high keeps it from repeating
    // in the cycle the master still has cyc up.
    always_ff @(posedge wb_clk) begin
        if (i_rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= sel && !ack_q;
        end
    end

    assign bus.ack = ack_q;

endmodule

`default_nettype wire

// ==== verilog/gpio_reg.sv ====
`default_nettype none

module gpio_reg (
    input  wire           wb_clk,
    input  wire           i_rst,
    periph_bus_if.periph  bus,
    output logic          o_gpio
);
    import soc_bus_pkg::*;
    import soc_periph_pkg::*;

    logic      level_q;
    bus_data_u rdt_v;

    // Latch the level bit on a selected write
    always_ff @(posedge wb_clk) begin
        if (i_rst) begin
            level_q <= GPIO_RESET_LEVEL;
        end else if (bus.cyc_sel && bus.we) begin
            level_q <= bus.wdat.gpio.level;
        end
    end

    // Read back in the GPIO view, zeros elsewhere
    always_comb begin
        rdt_v            = '0;
        rdt_v.gpio.level = level_q;
    end

    assign bus.rdt = rdt_v;
    assign o_gpio  = level_q;

endmodule

`default_nettype wire

// ==== uart/uart_baud.sv ====
`default_nettype none

module uart_baud (
    input  wire  wb_clk,
    input  wire  i_rst,
    output logic o_baud_en
);
    import soc_periph_pkg::*;

    logic [BAUD_CNT_W-1:0] cnt;

    // Down-counter, reloads after reaching zero
    always_ff @(posedge wb_clk) begin
        if (i_rst) begin
            cnt <= BAUD_CNT_W'(UART_DIVIDE - 1);
        end else if (cnt == '0) begin
            cnt <= BAUD_CNT_W'(UART_DIVIDE - 1);
        end else begin
            cnt <= cnt - BAUD_CNT_W'(1);
        end
    end

    // One pulse per reload
    assign o_baud_en = (cnt == '0);

endmodule

`default_nettype wire

// ==== uart/uart_tx.sv ====
`default_nettype none

module uart_tx (
    input  wire           wb_clk,
    input  wire           i_rst,
    input  wire           i_baud_en,
    periph_bus_if.periph  bus,
    output logic          o_tx
);
    import soc_bus_pkg::*;
    import soc_periph_pkg::*;

    logic [UART_FRAME_BITS-1:0] frame_q;
    logic [UART_CNT_W-1:0]      bit_cnt;
    logic                       ready_q;
    logic                       tx_q;
    logic                       load;
    logic                       shift_en;

    // Writes while busy are dropped
    assign load = bus.cyc_sel && bus.we && ready_q;

    // Bits still to put on the line
    assign shift_en = i_baud_en && !ready_q && (bit_cnt != '0);

    // Control and line state
    always_ff @(posedge wb_clk) begin
        if (i_rst) begin
            ready_q <= 1'b1;
            bit_cnt <= '0;
            tx_q    <= 1'b1;
        end else if (load) begin
            ready_q <= 1'b0;
            bit_cnt <= UART_CNT_W'(UART_FRAME_BITS);
        end else if (shift_en) begin
            tx_q    <= frame_q[0];
            bit_cnt <= bit_cnt - UART_CNT_W'(1);
        end else if (i_baud_en && !ready_q) begin
            // Stop bit has had its full baud period
            ready_q <= 1'b1;
        end
    end

    // Frame shifter, stop at the top and start at the bottom
    always_ff @(posedge wb_clk) begin
        if (load) begin
            frame_q <= {1'b1, bus.wdat.uart.tx_byte, 1'b0};
        end else if (shift_en) begin
            frame_q <= {1'b1, frame_q[UART_FRAME_BITS-1:1]};
        end
    end

    // Ready flag readable in bit 0
    assign bus.rdt = {{(BUS_DATA_W - 1){1'b0}}, ready_q};

    assign o_tx = tx_q;

endmodule

`default_nettype wire

// ==== verilog/soc_periph.sv ====
`default_nettype none

module soc_periph (
    input  wire                                wb_clk,
    input  wire                                i_rst_n,
    input  wire                                i_wb_cyc,
    input  wire                                i_wb_we,
    input  wire [soc_bus_pkg::BUS_ADDR_W-1:0]  i_wb_adr,
    input  wire [soc_bus_pkg::BUS_DATA_W-1:0]  i_wb_dat,
    output logic                               o_wb_ack,
    output logic [soc_bus_pkg::BUS_DATA_W-1:0] o_wb_rdt,
    output logic                               o_gpio,
    output logic                               o_uart_tx
);
    import soc_bus_pkg::*;

    logic             wb_rst;
    logic             baud_en;
    logic [SEL_W-1:0] sel_adr;

    periph_bus_if gpio_bus ();
    periph_bus_if uart_bus ();

    reset_stretch u_reset (
        .wb_clk  (wb_clk),
        .i_rst_n (i_rst_n),
        .o_rst   (wb_rst)
    );

    // Only the top byte takes part in decoding
    assign sel_adr = i_wb_adr[BUS_ADDR_W-1 -: SEL_W];

    bus_select #(.SLAVE_SEL(GPIO_BASE)) sel_gpio (
        .wb_clk    (wb_clk),
        .i_rst     (wb_rst),
        .i_wb_cyc  (i_wb_cyc),
        .i_wb_we   (i_wb_we),
        .i_wb_dat  (i_wb_dat),
        .i_sel_adr (sel_adr),
        .bus       (gpio_bus)
    );

    bus_select #(.SLAVE_SEL(UART_BASE)) sel_uart (
        .wb_clk    (wb_clk),
        .i_rst     (wb_rst),
        .i_wb_cyc  (i_wb_cyc),
        .i_wb_we   (i_wb_we),
        .i_wb_dat  (i_wb_dat),
        .i_sel_adr (sel_adr),
        .bus       (uart_bus)
    );

    gpio_reg u_gpio (
        .wb_clk (wb_clk),
        .i_rst  (wb_rst),
        .bus    (gpio_bus),
        .o_gpio (o_gpio)
    );

    uart_baud u_baud (
        .wb_clk    (wb_clk),
        .i_rst     (wb_rst),
        .o_baud_en (baud_en)
    );

    uart_tx u_uart (
        .wb_clk    (wb_clk),
        .i_rst     (wb_rst),
        .i_baud_en (baud_en),
        .bus       (uart_bus),
        .o_tx      (o_uart_tx)
    );

    // At most one slave acks at a time
    assign o_wb_ack = gpio_bus.ack | uart_bus.ack;

    // Read data from whichever slave is selected
    always_comb begin
        if (gpio_bus.cyc_sel) begin
            o_wb_rdt = gpio_bus.rdt;
        end else if (uart_bus.cyc_sel) begin
            o_wb_rdt = uart_bus.rdt;
        end else begin
            o_wb_rdt = '0;
        end
    end

endmodule

`default_nettype wire

// ==== dv/soc_periph_tb.sv ====
`default_nettype none

module soc_periph_tb;
    import soc_bus_pkg::*;
    import soc_periph_pkg::*;

    typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_POLL, OP_IDLE} op_e;

    // One bus step and what the bus and pins should show after it
    typedef struct {
        op_e                   op;
        logic [BUS_ADDR_W-1:0] adr;
        bus_data_u             dat;
        bus_data_u             exp_rdt;
        logic                  exp_gpio;
        int                    exp_frames;
    } step_t;

    localparam logic [BUS_ADDR_W-1:0] GPIO_ADR = {GPIO_BASE, 24'h000000};
    localparam logic [BUS_ADDR_W-1:0] UART_ADR = {UART_BASE, 24'h000010};
    // Long enough for a wrongly started frame to pull the line low
    localparam int IDLE_CYCLES = UART_DIVIDE + 8;

    logic                  wb_clk = 1'b0;
    logic                  i_rst_n;
    logic                  i_wb_cyc;
    logic                  i_wb_we;
    logic [BUS_ADDR_W-1:0] i_wb_adr;
    logic [BUS_DATA_W-1:0] i_wb_dat;
    logic                  o_wb_ack;
    logic [BUS_DATA_W-1:0] o_wb_rdt;
    logic                  o_gpio;
    logic                  o_uart_tx;

    step_t      steps[$];
    logic [7:0] sent_bytes[$];
    logic [7:0] rx_bytes[$];
    integer     seed;
    int         cycle_cnt = 0;
    int         timeout_limit = 0;
    int         uart_writes = 0;
    logic       model_gpio;
    logic       model_ready;
    int         model_frames;
    logic       rst_done = 1'b0;

    soc_periph UUT (
        .wb_clk    (wb_clk),
        .i_rst_n   (i_rst_n),
        .i_wb_cyc  (i_wb_cyc),
        .i_wb_we   (i_wb_we),
        .i_wb_adr  (i_wb_adr),
        .i_wb_dat  (i_wb_dat),
        .o_wb_ack  (o_wb_ack),
        .o_wb_rdt  (o_wb_rdt),
        .o_gpio    (o_gpio),
        .o_uart_tx (o_uart_tx)
    );

    always #4 wb_clk = ~wb_clk;

    always @(posedge wb_clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (timeout_limit > 0 && cycle_cnt >= timeout_limit) begin
            $display("Simulation timed out after %0d cycles", cycle_cnt);
            $display("Test failed");
            $fatal(1, "Timeout");
        end
    end

    task automatic report_error(input string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        $display("Test failed");
        $fatal(1, "Check failed");
    endtask

    task automatic check_rdt(input bus_data_u got, input bus_data_u exp, input string what);
        if (got !== exp) begin
            report_error($sformatf("%s: got %h, expected %h", what, got, exp));
        end
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp) begin
            report_error($sformatf("%s: got %h, expected %h", what, got, exp));
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_error($sformatf("%s: got %b, expected %b", what, got, exp));
        end
    endtask

    task automatic add_step(input op_e op, input logic [BUS_ADDR_W-1:0] adr,
                            input bus_data_u dat, input bus_data_u exp_rdt);
        step_t s;
        s.op         = op;
        s.adr        = adr;
        s.dat        = dat;
        s.exp_rdt    = exp_rdt;
        s.exp_gpio   = model_gpio;
        s.exp_frames = model_frames;
        steps.push_back(s);
    endtask

    task automatic gpio_write_step(input logic level);
        bus_data_u d;
        d            = '0;
        d.gpio.level = level;
        model_gpio   = level;
        add_step(OP_WRITE, GPIO_ADR, d, '0);
    endtask

    task automatic gpio_read_step();
        bus_data_u r;
        r            = '0;
        r.gpio.level = model_gpio;
        add_step(OP_READ, GPIO_ADR, '0, r);
    endtask

    task automatic uart_write_step(input logic [7:0] b);
        bus_data_u d;
        d              = '0;
        d.uart.tx_byte = b;
        // Only an idle transmitter takes the byte
        if (model_ready) begin
            sent_bytes.push_back(b);
            model_ready = 1'b0;
        end
        uart_writes++;
        add_step(OP_WRITE, UART_ADR, d, '0);
    endtask

    task automatic uart_read_step();
        add_step(OP_READ, UART_ADR, '0, BUS_DATA_W'(model_ready));
    endtask

    task automatic ready_poll_step();
        model_ready  = 1'b1;
        model_frames = sent_bytes.size();
        add_step(OP_POLL, UART_ADR, '0, BUS_DATA_W'(1'b1));
    endtask

    task automatic idle_step();
        add_step(OP_IDLE, GPIO_ADR, '0, '0);
    endtask

    task automatic build_table();
        model_gpio   = GPIO_RESET_LEVEL;
        model_ready  = 1'b1;
        model_frames = 0;
        uart_read_step();
        gpio_read_step();
        repeat (2) begin
            gpio_write_step(1'($random(seed)));
            gpio_read_step();
            idle_step();
        end
        // Second byte lands while busy and is dropped
        uart_write_step(8'($random(seed)));
        uart_read_step();
        uart_write_step(8'($random(seed)));
        uart_read_step();
        ready_poll_step();
        repeat (2) begin
            uart_write_step(8'($random(seed)));
            gpio_write_step(1'($random(seed)));
            gpio_read_step();
            ready_poll_step();
        end
        gpio_write_step(~model_gpio);
        idle_step();
        timeout_limit = (uart_writes * UART_FRAME_BITS + 2) * UART_DIVIDE
                        + 50 * steps.size();
    endtask

    task automatic bus_transfer(input logic we, input logic [BUS_ADDR_W-1:0] adr,
                                input bus_data_u dat, output bus_data_u rd);
        int cycles;
        i_wb_cyc = 1'b1;
        i_wb_we  = we;
        i_wb_adr = adr;
        i_wb_dat = dat;
        @(negedge wb_clk);
        cycles = 1;
        while (!o_wb_ack) begin
            @(negedge wb_clk);
            cycles++;
        end
        rd = o_wb_rdt;
        if (cycles != 1) begin
            report_error($sformatf("ack in cycle %0d of the transfer, expected 2", cycles + 1));
        end
        // Master samples ack on the edge, so cyc is still up there
        @(negedge wb_clk);
        check_bit(o_wb_ack, 1'b0, "ack repeated while cyc held");
        i_wb_cyc = 1'b0;
        i_wb_we  = 1'b0;
        @(negedge wb_clk);
        check_bit(o_wb_ack, 1'b0, "ack after the acknowledged cycle");
    endtask

    task automatic bus_write(input logic [BUS_ADDR_W-1:0] adr, input bus_data_u dat);
        bus_data_u discard;
        bus_transfer(1'b1, adr, dat, discard);
    endtask

    task automatic bus_read(input logic [BUS_ADDR_W-1:0] adr, output bus_data_u rd);
        bus_transfer(1'b0, adr, '0, rd);
    endtask

    task automatic poll_ready(input step_t s);
        bus_data_u rd;
        bus_read(s.adr, rd);
        while (rd[0] !== 1'b1) begin
            bus_read(s.adr, rd);
        end
        check_rdt(rd, s.exp_rdt, "UART status after polling");
    endtask

    task automatic check_frames(input step_t s);
        int i;
        if (rx_bytes.size() != s.exp_frames) begin
            report_error($sformatf("%0d UART frames received, expected %0d",
                                   rx_bytes.size(), s.exp_frames));
        end
        for (i = 0; i < s.exp_frames; i++) begin
            check_byte(rx_bytes[i], sent_bytes[i], "UART frame byte");
        end
    endtask

    task automatic watch_idle_line(input step_t s);
        repeat (IDLE_CYCLES) begin
            @(negedge wb_clk);
            check_bit(o_uart_tx, 1'b1, "UART line while idle");
        end
        check_frames(s);
    endtask

    // Decode 8N1 frames, sampling near the middle of each bit
    initial begin : uart_monitor
        logic [7:0] data;
        int         i;
        wait (rst_done);
        forever begin
            @(negedge o_uart_tx);
            repeat (UART_DIVIDE / 2) @(negedge wb_clk);
            check_bit(o_uart_tx, 1'b0, "UART start bit");
            for (i = 0; i < 8; i++) begin
                repeat (UART_DIVIDE) @(negedge wb_clk);
                data[i] = o_uart_tx;
            end
            repeat (UART_DIVIDE) @(negedge wb_clk);
            check_bit(o_uart_tx, 1'b1, "UART stop bit");
            rx_bytes.push_back(data);
        end
    end

    initial begin
        step_t     s;
        bus_data_u rd;
        seed     = 32'hcd55_b62d;
        i_rst_n  = 1'b0;
        i_wb_cyc = 1'b0;
        i_wb_we  = 1'b0;
        i_wb_adr = '0;
        i_wb_dat = '0;
        build_table();
        repeat (3) @(negedge wb_clk);
        i_rst_n = 1'b1;
        // UART status read held open while the internal reset is stretched
        i_wb_cyc = 1'b1;
        i_wb_adr = UART_ADR;
        repeat (RST_STRETCH) begin
            @(negedge wb_clk);
            check_bit(o_gpio, GPIO_RESET_LEVEL, "GPIO level in reset");
            check_bit(o_uart_tx, 1'b1, "UART line in reset");
            check_bit(o_wb_ack, 1'b0, "ack in reset");
            check_rdt(o_wb_rdt, BUS_DATA_W'(1'b1), "UART status in reset");
        end
        i_wb_cyc = 1'b0;
        @(negedge wb_clk);
        rst_done = 1'b1;
        foreach (steps[k]) begin
            s = steps[k];
            case (s.op)
                OP_WRITE: bus_write(s.adr, s.dat);
                OP_READ: begin
                    bus_read(s.adr, rd);
                    check_rdt(rd, s.exp_rdt, "read data");
                end
                OP_POLL: begin
                    poll_ready(s);
                    check_frames(s);
                end
                default: watch_idle_line(s);
            endcase
            check_bit(o_gpio, s.exp_gpio, "GPIO output level");
        end
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== soc_periph.f ====
common/soc_bus_pkg.sv
common/soc_periph_pkg.sv
common/periph_bus_if.sv
verilog/reset_stretch.sv
verilog/bus_select.sv
verilog/gpio_reg.sv
uart/uart_baud.sv
uart/uart_tx.sv
verilog/soc_periph.sv
dv/soc_periph_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --timing -j 0
LINTFLAGS = --lint-only --timing
TOP       = soc_periph_tb
FILELIST  = soc_periph.f
LOG       = sim.log
SIM_BIN   = obj_dir/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "^Test passed$$" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
